/* cgra_consts.svh */
/*
 * Array geometry and field widths of the CGRA.
 * The PE address is row * CGRA_COLS + column, so CGRA_ADDR_W must cover CGRA_NUM_PE.
 */
`ifndef CGRA_CONSTS_SVH
`define CGRA_CONSTS_SVH

// Grid size
`define CGRA_ROWS    4
`define CGRA_COLS    4
`define CGRA_NUM_PE  16

// Lane payload
`define CGRA_DATA_W  32

// Configuration fields
`define CGRA_IMM_W   16
`define CGRA_ADDR_W  4
`define CGRA_OP_W    3

`endif

/* cgra_pkg.sv */
/*
 * Types shared by the CGRA: ALU opcodes, operand sources, configuration frames and lanes.
 * Operand A is taken from north or west only. The immediate is zero-extended.
 */
package cgra_pkg;

    `include "cgra_consts.svh"

    typedef enum logic [`CGRA_OP_W-1:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        PASS_A,
        SHL,
        MUL_LO
    } alu_op_e;

    // Operand B source, IMM is not valid for A
    typedef enum logic [1:0] {
        NORTH = 2'd0,
        WEST  = 2'd1,
        IMM   = 2'd2
    } src_sel_e;

    typedef struct packed {
        alu_op_e                 op;
        logic                    a_sel;    // 0 north, 1 west
        src_sel_e                b_sel;
        logic                    route_s;
        logic                    route_e;
        logic [`CGRA_IMM_W-1:0]  imm;
    } pe_cfg_t;

    typedef struct packed {
        logic [`CGRA_ADDR_W-1:0] pe_addr;
        pe_cfg_t                 cfg;
    } cfg_frame_t;

    typedef struct packed {
        logic                    valid;
        logic [`CGRA_DATA_W-1:0] data;
    } lane_t;

    // Indexed by column
    typedef lane_t [`CGRA_COLS-1:0] lane_bus_t;

endpackage

/* cgra_alu.sv */
/*
 * Combinational PE datapath. All results wrap modulo 2^32.
 * SHL uses only the low 5 bits of B.
 */
`timescale 1ns/1ns

module cgra_alu (
    input  cgra_pkg::alu_op_e op_i,
    input  logic [31:0]       a_i,
    input  logic [31:0]       b_i,
    output logic [31:0]       res_o
);

    always_comb begin
        case (op_i)
            cgra_pkg::ADD: begin
                res_o = a_i + b_i;
            end
            cgra_pkg::SUB: begin
                res_o = a_i - b_i;
            end
            cgra_pkg::AND: begin
                res_o = a_i & b_i;
            end
            cgra_pkg::OR: begin
                res_o = a_i | b_i;
            end
            cgra_pkg::XOR: begin
                res_o = a_i ^ b_i;
            end
            cgra_pkg::PASS_A: begin
                res_o = a_i;
            end
            cgra_pkg::SHL: begin
                res_o = a_i << b_i[4:0];
            end
            default: begin
                // Low half of the product
                res_o = a_i * b_i;
            end
        endcase
    end

endmodule

/* cgra_pe.sv */
/*
 * One processing element. Fires when run_i is high, all selected operands are valid
 * and the result register is free. The result is offered south and/or east one cycle
 * later. A PE routed to neither direction drops its result.
 */
`timescale 1ns/1ns
`include "cgra_consts.svh"

module cgra_pe (
    input  logic              clk,
    input  logic              rst_n_bs,
    input  cgra_pkg::pe_cfg_t cfg_i,
    input  logic              cfg_load_i,
    input  logic              run_i,
    input  cgra_pkg::lane_t   north_i,
    output logic              north_ready_o,
    input  cgra_pkg::lane_t   west_i,
    output logic              west_ready_o,
    output cgra_pkg::lane_t   south_o,
    input  logic              south_ready_i,
    output cgra_pkg::lane_t   east_o,
    input  logic              east_ready_i
);

    cgra_pkg::pe_cfg_t        cfg_q;
    logic                     need_n;
    logic                     need_w;
    logic                     operands_ok;
    logic                     res_free;
    logic                     fire;
    logic [`CGRA_DATA_W-1:0]  opnd_a;
    logic [`CGRA_DATA_W-1:0]  opnd_b;
    logic [`CGRA_DATA_W-1:0]  alu_res;
    logic [`CGRA_DATA_W-1:0]  res_q;
    logic                     pend_s;
    logic                     pend_e;

    always_ff @(posedge clk or negedge rst_n_bs) begin
        if (!rst_n_bs) begin
            cfg_q <= '0;
        end else if (cfg_load_i) begin
            cfg_q <= cfg_i;
        end
    end

    // Which lanes this configuration consumes
    assign need_n = !cfg_q.a_sel || (cfg_q.b_sel == cgra_pkg::NORTH);
    assign need_w = cfg_q.a_sel || (cfg_q.b_sel == cgra_pkg::WEST);

    assign operands_ok = (!need_n || north_i.valid) && (!need_w || west_i.valid);

    // Free when every pending copy leaves this cycle
    assign res_free = (!pend_s || south_ready_i) && (!pend_e || east_ready_i);

    assign fire = run_i && operands_ok && res_free;

    // Join: a lane is taken only together with its partner
    assign north_ready_o = fire && need_n;
    assign west_ready_o  = fire && need_w;

    assign opnd_a = cfg_q.a_sel ? west_i.data : north_i.data;

    always_comb begin
        case (cfg_q.b_sel)
            cgra_pkg::NORTH: begin
                opnd_b = north_i.data;
            end
            cgra_pkg::WEST: begin
                opnd_b = west_i.data;
            end
            default: begin
                opnd_b = {{(`CGRA_DATA_W - `CGRA_IMM_W){1'b0}}, cfg_q.imm};
            end
        endcase
    end

    cgra_alu u_alu (
        .op_i  (cfg_q.op),
        .a_i   (opnd_a),
        .b_i   (opnd_b),
        .res_o (alu_res)
    );

    always_ff @(posedge clk) begin
        if (fire) begin
            res_q <= alu_res;
        end
    end

    // Fork flags, one per route
    always_ff @(posedge clk or negedge rst_n_bs) begin
        if (!rst_n_bs) begin
            pend_s <= 1'b0;
            pend_e <= 1'b0;
        end else begin
            if (fire) begin
                pend_s <= cfg_q.route_s;
            end else if (south_ready_i) begin
                pend_s <= 1'b0;
            end
            if (fire) begin
                pend_e <= cfg_q.route_e;
            end else if (east_ready_i) begin
                pend_e <= 1'b0;
            end
        end
    end

    assign south_o = '{valid: pend_s, data: res_q};
    assign east_o  = '{valid: pend_e, data: res_q};

    // Offered results hold until taken
    a_south_stable: assert property (@(posedge clk) disable iff (!rst_n_bs)
        south_o.valid && !south_ready_i |=> south_o.valid && $stable(south_o.data));
    a_east_stable: assert property (@(posedge clk) disable iff (!rst_n_bs)
        east_o.valid && !east_ready_i |=> east_o.valid && $stable(east_o.data));

    // Operand B source is one of the defined encodings while running
    a_bsel_legal: assert property (@(posedge clk) disable iff (!rst_n_bs)
        run_i |-> cfg_q.b_sel inside {cgra_pkg::NORTH, cgra_pkg::WEST, cgra_pkg::IMM});

endmodule

/* cgra_mesh.sv */
/*
 * 4x4 grid of PEs with data flowing south and east only.
 * West-edge inputs are never valid and east-edge outputs are always taken and dropped.
 */
`timescale 1ns/1ns
`include "cgra_consts.svh"

module cgra_mesh (
    input  logic                                clk,
    input  logic                                rst_n_bs,
    input  cgra_pkg::pe_cfg_t                   cfg_i,
    input  logic [`CGRA_NUM_PE-1:0]             cfg_load_i,
    input  logic [`CGRA_NUM_PE-1:0]             run_i,
    input  cgra_pkg::lane_bus_t                 north_i,
    output logic [`CGRA_COLS-1:0]               north_ready_o,
    output cgra_pkg::lane_bus_t                 south_o,
    input  logic [`CGRA_COLS-1:0]               south_ready_i
);

    // Vertical links, row index ROWS is the south edge
    cgra_pkg::lane_t ns     [`CGRA_ROWS+1][`CGRA_COLS];
    logic            ns_rdy [`CGRA_ROWS+1][`CGRA_COLS];

    // Horizontal links, column index COLS is the east edge
    cgra_pkg::lane_t we     [`CGRA_ROWS][`CGRA_COLS+1];
    logic            we_rdy [`CGRA_ROWS][`CGRA_COLS+1];

    for (genvar c = 0; c < `CGRA_COLS; c++) begin : g_edge_ns
        assign ns[0][c]             = north_i[c];
        assign north_ready_o[c]     = ns_rdy[0][c];
        assign south_o[c]           = ns[`CGRA_ROWS][c];
        assign ns_rdy[`CGRA_ROWS][c] = south_ready_i[c];
    end

    for (genvar r = 0; r < `CGRA_ROWS; r++) begin : g_edge_we
        assign we[r][0]              = '0;
        assign we_rdy[r][`CGRA_COLS] = 1'b1;
    end

    for (genvar r = 0; r < `CGRA_ROWS; r++) begin : g_row
        for (genvar c = 0; c < `CGRA_COLS; c++) begin : g_col
            cgra_pe u_pe (
                .clk           (clk),
                .rst_n_bs      (rst_n_bs),
                .cfg_i         (cfg_i),
                .cfg_load_i    (cfg_load_i[r*`CGRA_COLS + c]),
                .run_i         (run_i[r*`CGRA_COLS + c]),
                .north_i       (ns[r][c]),
                .north_ready_o (ns_rdy[r][c]),
                .west_i        (we[r][c]),
                .west_ready_o  (we_rdy[r][c]),
                .south_o       (ns[r+1][c]),
                .south_ready_i (ns_rdy[r+1][c]),
                .east_o        (we[r][c+1]),
                .east_ready_i  (we_rdy[r][c+1])
            );
        end
    end

endmodule

/* cgra_cfg_decode.sv */
/*
 * Configuration address decode. A PE counts as configured from the cycle after its
 * first frame until reset, and runs only while configured and execute_i is high.
 */
`timescale 1ns/1ns
`include "cgra_consts.svh"

module cgra_cfg_decode (
    input  logic                     clk,
    input  logic                     rst_n_bs,
    input  logic                     cfg_we_i,
    input  logic [`CGRA_ADDR_W-1:0]  pe_addr_i,
    input  logic                     execute_i,
    output logic [`CGRA_NUM_PE-1:0]  cfg_load_o,
    output logic [`CGRA_NUM_PE-1:0]  pe_run_o
);

    logic [`CGRA_NUM_PE-1:0] configured_q;

    always_comb begin
        for (int i = 0; i < `CGRA_NUM_PE; i++) begin
            cfg_load_o[i] = cfg_we_i && (pe_addr_i == i[`CGRA_ADDR_W-1:0]);
        end
    end

    always_ff @(posedge clk or negedge rst_n_bs) begin
        if (!rst_n_bs) begin
            configured_q <= '0;
        end else begin
            configured_q <= configured_q | cfg_load_o;
        end
    end

    assign pe_run_o = configured_q & {`CGRA_NUM_PE{execute_i}};

    // At most one PE loads per strobe
    a_load_onehot: assert property (@(posedge clk) disable iff (!rst_n_bs)
        $onehot0(cfg_load_o));

endmodule

/* cgra_top.sv */
/*
 * CGRA top level. Frames load on clk with cfg_we_i, one PE per strobe.
 * Data enters the north of row 0 and leaves the south of row 3.
 */
`timescale 1ns/1ns

module cgra_top (
    input  logic                   clk,
    input  logic                   rst_n_bs,
    input  cgra_pkg::lane_bus_t    din_i,
    output logic [3:0]             din_ready_o,
    output cgra_pkg::lane_bus_t    dout_o,
    input  logic [3:0]             dout_ready_i,
    input  cgra_pkg::cfg_frame_t   cfg_i,
    input  logic                   cfg_we_i,
    input  logic                   execute_i
);

    logic [15:0] cfg_load;
    logic [15:0] pe_run;

    cgra_cfg_decode u_cfg_decode (
        .clk        (clk),
        .rst_n_bs   (rst_n_bs),
        .cfg_we_i   (cfg_we_i),
        .pe_addr_i  (cfg_i.pe_addr),
        .execute_i  (execute_i),
        .cfg_load_o (cfg_load),
        .pe_run_o   (pe_run)
    );

    cgra_mesh u_mesh (
        .clk           (clk),
        .rst_n_bs      (rst_n_bs),
        .cfg_i         (cfg_i.cfg),
        .cfg_load_i    (cfg_load),
        .run_i         (pe_run),
        .north_i       (din_i),
        .north_ready_o (din_ready_o),
        .south_o       (dout_o),
        .south_ready_i (dout_ready_i)
    );

endmodule

/* tb_clk_gen.sv */
/*
 * Testbench clock and reset. Clock period is 10 ns.
 * Reset is low from time 0 and released on the third rising edge.
 */
`timescale 1ns/1ns

module tb_clk_gen (
    output logic clk_o,
    output logic rst_n_bs_o
);

    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

    initial begin
        rst_n_bs_o <= 1'b0;
        repeat (3) @(posedge clk_o);
        rst_n_bs_o <= 1'b1;
    end

endmodule

/* tb_cgra.sv */
/*
 * Random-stimulus testbench for cgra_top with a transaction-level model per lane.
 * Outputs are checked by order and value. Latency is checked only without back-pressure.
 * Inputs change on the rising edge and handshakes are sampled on the falling edge.
 */
`timescale 1ns/1ns
`include "cgra_consts.svh"

module tb_cgra;

    // Five tests of about 200 words, worst stall about 20 cycles per word
    localparam int MAX_CYCLES = 5 * 200 * 20;
    localparam int NC         = `CGRA_COLS;

    logic                  clk;
    logic                  rst_n_bs;
    cgra_pkg::lane_bus_t   din;
    logic [NC-1:0]         din_ready;
    cgra_pkg::lane_bus_t   dout;
    logic [NC-1:0]         dout_ready;
    cgra_pkg::cfg_frame_t  cfg_frame;
    logic                  cfg_we;
    logic                  execute;

    // Model of the array
    logic [31:0] exp_q [NC][$];
    int          t_q [NC][$];
    logic [31:0] join_a [$];
    logic [31:0] join_b [$];
    logic [2:0]  row0_op [NC];
    logic [31:0] row0_imm [NC];
    bit          join_mode = 1'b0;
    bit          lat_check = 1'b0;

    // Stimulus state
    int  send_left [NC];
    int  in_cnt [NC];
    int  out_cnt [NC];
    bit  in_fire [NC];
    int  valid_pct = 0;
    int  ready_pct = 0;
    bit  exec_want = 1'b1;

    int  cyc = 0;
    int  errors = 0;
    int  tests_run = 0;
    int  tests_failed = 0;

    tb_clk_gen u_clk_gen (
        .clk_o      (clk),
        .rst_n_bs_o (rst_n_bs)
    );

    cgra_top uut (
        .clk          (clk),
        .rst_n_bs     (rst_n_bs),
        .din_i        (din),
        .din_ready_o  (din_ready),
        .dout_o       (dout),
        .dout_ready_i (dout_ready),
        .cfg_i        (cfg_frame),
        .cfg_we_i     (cfg_we),
        .execute_i    (execute)
    );

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= MAX_CYCLES) begin
            $display("timeout, the run did not finish within %0d cycles", MAX_CYCLES);
            $display("tests failed");
            $finish;
        end
    end

    // Opcode order ADD SUB AND OR XOR PASS_A SHL MUL_LO
    function automatic logic [31:0] alu_model(input logic [2:0] op, input logic [31:0] a,
                                              input logic [31:0] b);
        case (op)
            3'd0: return a + b;
            3'd1: return a - b;
            3'd2: return a & b;
            3'd3: return a | b;
            3'd4: return a ^ b;
            3'd5: return a;
            3'd6: return a << b[4:0];
            default: return a * b;
        endcase
    endfunction

    // Operand A always from north, always routed south
    function automatic cgra_pkg::pe_cfg_t make_cfg(input logic [2:0] op, input logic [1:0] b_sel,
                                                   input logic route_e, input logic [15:0] imm);
        cgra_pkg::pe_cfg_t pc;
        pc.op      = cgra_pkg::alu_op_e'(op);
        pc.a_sel   = 1'b0;
        pc.b_sel   = cgra_pkg::src_sel_e'(b_sel);
        pc.route_s = 1'b1;
        pc.route_e = route_e;
        pc.imm     = imm;
        return pc;
    endfunction

    task automatic load_frame(input int addr, input cgra_pkg::pe_cfg_t pc);
        cgra_pkg::cfg_frame_t f;
        f.pe_addr = 4'(addr);
        f.cfg     = pc;
        @(posedge clk);
        cfg_frame <= f;
        cfg_we    <= 1'b1;
        @(posedge clk);
        cfg_we    <= 1'b0;
        @(negedge clk);
    endtask

    task automatic accept(input int c, input logic [31:0] w);
        in_cnt[c]++;
        if (join_mode && c == 1) begin
            join_b.push_back(w);
        end else begin
            exp_q[c].push_back(alu_model(row0_op[c], w, row0_imm[c]));
            t_q[c].push_back(cyc);
            if (join_mode && c == 0) begin
                join_a.push_back(w);
            end
        end
    endtask

    task automatic check_out(input int c, input logic [31:0] d);
        logic [31:0] e;
        int          t;
        out_cnt[c]++;
        assert (exp_q[c].size() > 0) else begin
            $display("lane %0d delivered a word that was never sent", c);
            errors++;
        end
        if (exp_q[c].size() > 0) begin
            e = exp_q[c].pop_front();
            t = t_q[c].pop_front();
            assert (d == e) else begin
                $display("ERR dout_o[%0d].data expected %h got %h", c, e, d);
                errors++;
            end
            if (lat_check) begin
                assert (cyc - t == 4) else begin
                    $display("ERR dout_o[%0d] latency expected %h got %h", c, 4, cyc - t);
                    errors++;
                end
            end
        end
    endtask

    // Sampled on the falling edge, so each transfer here happens on the next rising edge
    task automatic monitor();
        for (int c = 0; c < NC; c++) begin
            in_fire[c] = din[c].valid && din_ready[c];
            if (in_fire[c]) begin
                accept(c, din[c].data);
            end
            if (dout[c].valid && dout_ready[c]) begin
                check_out(c, dout[c].data);
            end
        end
        // PE 1 adds its north word to the east copy of PE 0
        while (join_a.size() > 0 && join_b.size() > 0) begin
            exp_q[1].push_back(alu_model(3'd0, join_b.pop_front(), join_a.pop_front()));
            t_q[1].push_back(cyc);
        end
        if (!execute) begin
            assert (din_ready == '0) else begin
                $display("ERR din_ready_o expected %h got %h", 4'h0, din_ready);
                errors++;
            end
        end
    endtask

    task automatic drive();
        cgra_pkg::lane_t ln;
        for (int c = 0; c < NC; c++) begin
            // Hold a word until it is taken
            if (in_fire[c] || !din[c].valid) begin
                ln = '0;
                if (send_left[c] > 0 && ($urandom % 100) < valid_pct) begin
                    ln.valid = 1'b1;
                    ln.data  = $urandom;
                    send_left[c]--;
                end
                din[c] <= ln;
            end
            dout_ready[c] <= ($urandom % 100) < ready_pct;
        end
        execute <= exec_want;
    endtask

    task automatic step();
        @(posedge clk);
        drive();
        @(negedge clk);
        monitor();
    endtask

    function automatic bit busy();
        bit b;
        b = join_a.size() > 0 || join_b.size() > 0;
        for (int c = 0; c < NC; c++) begin
            b = b || send_left[c] > 0 || din[c].valid || exp_q[c].size() > 0;
        end
        return b;
    endfunction

    task automatic start_stream(input int words, input int vpct, input int rpct);
        for (int c = 0; c < NC; c++) begin
            send_left[c] = words;
        end
        valid_pct = vpct;
        ready_pct = rpct;
    endtask

    task automatic drain();
        while (busy()) begin
            step();
        end
        // Idle cycles catch any extra output
        repeat (10) step();
    endtask

    task automatic report_test(input string name, input int err_start);
        tests_run++;
        if (errors == err_start) begin
            $display("test %s ok", name);
        end else begin
            tests_failed++;
            $display("test %s FAILED with %0d errors", name, errors - err_start);
        end
    endtask

    initial begin
        int         err0;
        int         snap_out [NC];
        int         snap_in [NC];
        logic [7:0] used;
        int         pass;
        logic [2:0] op;
        logic [15:0] imm;

        void'($urandom(32'ha8ac));
        din        <= '0;
        dout_ready <= '0;
        cfg_frame  <= '0;
        cfg_we     <= 1'b0;
        execute    <= 1'b0;
        wait (rst_n_bs === 1'b1);
        @(negedge clk);

        // Unconfigured array must stay silent
        err0 = errors;
        repeat (50) begin
            @(posedge clk);
            execute <= 1'b1;
            for (int c = 0; c < NC; c++) begin
                din[c].valid  <= 1'b1;
                din[c].data   <= $urandom;
                dout_ready[c] <= 1'($urandom);
            end
            @(negedge clk);
            assert (din_ready == '0) else begin
                $display("ERR din_ready_o expected %h got %h", 4'h0, din_ready);
                errors++;
            end
            for (int c = 0; c < NC; c++) begin
                assert (!dout[c].valid) else begin
                    $display("ERR dout_o[%0d].valid expected %h got %h", c, 1'b0, 1'b1);
                    errors++;
                end
            end
        end
        @(posedge clk);
        din <= '0;
        @(negedge clk);
        report_test("reset_unconfigured", err0);

        err0 = errors;
        for (int a = 0; a < `CGRA_NUM_PE; a++) begin
            load_frame(a, make_cfg(3'd5, 2'd0, 1'b0, 16'h0));
        end
        for (int c = 0; c < NC; c++) begin
            row0_op[c]  = 3'd5;
            row0_imm[c] = '0;
        end
        start_stream(150, 70, 70);
        drain();
        lat_check = 1'b1;
        start_stream(50, 70, 100);
        drain();
        lat_check = 1'b0;
        report_test("pass_through", err0);

        err0 = errors;
        used = '0;
        pass = 0;
        while (used != 8'hff) begin
            for (int c = 0; c < NC; c++) begin
                op  = 3'($urandom);
                imm = 16'($urandom);
                // Late passes pick the lowest opcode not yet seen
                if (pass >= 3) begin
                    for (int k = 7; k >= 0; k--) begin
                        if (!used[k]) begin
                            op = 3'(k);
                        end
                    end
                end
                used[op]    = 1'b1;
                row0_op[c]  = op;
                row0_imm[c] = {16'h0, imm};
                load_frame(c, make_cfg(op, 2'd2, 1'b0, imm));
            end
            start_stream(40, 80, 70);
            drain();
            pass++;
        end
        report_test("alu_ops", err0);

        err0 = errors;
        for (int c = 0; c < NC; c++) begin
            load_frame(c, make_cfg(3'd5, 2'd0, 1'b0, 16'h0));
            row0_op[c] = 3'd5;
        end
        start_stream(120, 90, 80);
        repeat (40) step();
        exec_want = 1'b0;
        snap_out  = out_cnt;
        snap_in   = in_cnt;
        repeat (20) step();
        for (int c = 0; c < NC; c++) begin
            assert (out_cnt[c] - snap_out[c] <= 3) else begin
                $display("lane %0d released more than three words with execute low", c);
                errors++;
            end
            assert (in_cnt[c] == snap_in[c]) else begin
                $display("lane %0d accepted input with execute low", c);
                errors++;
            end
        end
        exec_want = 1'b1;
        drain();
        report_test("execute_gating", err0);

        err0 = errors;
        join_mode = 1'b1;
        load_frame(0, make_cfg(3'd5, 2'd0, 1'b1, 16'h0));
        load_frame(1, make_cfg(3'd0, 2'd1, 1'b0, 16'h0));
        start_stream(150, 70, 70);
        drain();
        join_mode = 1'b0;
        report_test("east_join_fork", err0);

        $display("%0d tests run, %0d passed, %0d failed, %0d errors",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* all.f */
+incdir+.
cgra_pkg.sv
cgra_alu.sv
cgra_pe.sv
cgra_mesh.sv
cgra_cfg_decode.sv
cgra_top.sv
tb_clk_gen.sv
tb_cgra.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_cgra
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= all.f
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns -j 0

SRCS := $(shell grep -v '^+' $(FILELIST)) cgra_consts.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "tests failed" $(LOG); then exit 1; fi
	@grep -q "all tests passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
